// File: Bender.yml
package:
  name: load_queue

sources:
  - lq_pkg.sv
  - lq_dispatch.sv
  - lq_entry.sv
  - lq_drain.sv
  - load_queue.sv
  - target: simulation
    files:
      - lq_checker.sv
      - tb_load_queue.sv

// File: files.f
lq_pkg.sv
lq_dispatch.sv
lq_entry.sv
lq_drain.sv
load_queue.sv
lq_checker.sv
tb_load_queue.sv

// File: load_queue.sv
`timescale 1ns/1ps

module load_queue
	import lq_pkg::*;
(
	input  logic         clock,
	input  logic         reset,
	input  logic         clean,
	input  lq_dispatch_t disp0,
	input  lq_dispatch_t disp1,
	output logic         disp_credit,
	input  cdb_t         cdb1,
	input  cdb_t         cdb2,
	output logic         mem_req_valid,
	output lq_mem_req_t  mem_req,
	input  logic         mem_req_ready,
	input  lq_mem_resp_t mem_resp,
	output logic         wb_valid,
	output lq_wb_t       wb,
	input  logic         wb_ready
);

	lq_entry_status_t    status [LQ_DEPTH];
	lq_wb_t              wb_rec [LQ_DEPTH];
	logic [LQ_DEPTH-1:0] entry_inuse;
	logic [LQ_DEPTH-1:0] alloc;
	logic [LQ_DEPTH-1:0] alloc_slot;
	logic [LQ_DEPTH-1:0] issued;
	logic [LQ_DEPTH-1:0] resp_strobe;
	logic [LQ_DEPTH-1:0] free;
	logic [XLEN-1:0]     resp_data;

	lq_dispatch u_dispatch (
		.clock       (clock),
		.reset       (reset),
		.clean       (clean),
		.disp0       (disp0),
		.disp1       (disp1),
		.entry_inuse (entry_inuse),
		.entry_free  (free),
		.alloc       (alloc),
		.alloc_slot  (alloc_slot),
		.disp_credit (disp_credit)
	);

	for (genvar i = 0; i < LQ_DEPTH; i++) begin : g_entry
		lq_entry u_entry (
			.clock       (clock),
			.reset       (reset),
			.clean       (clean),
			.alloc       (alloc[i]),
			.alloc_slot  (alloc_slot[i]),
			.disp0       (disp0),
			.disp1       (disp1),
			.cdb1        (cdb1),
			.cdb2        (cdb2),
			.issued      (issued[i]),
			.resp_strobe (resp_strobe[i]),
			.resp_data   (resp_data),
			.free        (free[i]),
			.status      (status[i]),
			.wb_rec      (wb_rec[i])
		);

		assign entry_inuse[i] = status[i].inuse;
	end

	lq_drain u_drain (
		.clock         (clock),
		.reset         (reset),
		.clean         (clean),
		.status        (status),
		.wb_rec        (wb_rec),
		.mem_req_ready (mem_req_ready),
		.mem_resp      (mem_resp),
		.wb_ready      (wb_ready),
		.mem_req_valid (mem_req_valid),
		.mem_req       (mem_req),
		.issued        (issued),
		.resp_strobe   (resp_strobe),
		.resp_data     (resp_data),
		.wb_valid      (wb_valid),
		.wb            (wb),
		.free          (free)
	);

endmodule

// File: lq_checker.sv
`timescale 1ns/1ps

module lq_checker
	import lq_pkg::*;
(
	input logic         clock,
	input logic         reset,
	input logic         clean,
	input lq_dispatch_t disp0,
	input lq_dispatch_t disp1,
	input logic         disp_credit,
	input logic         mem_req_valid,
	input lq_mem_req_t  mem_req,
	input logic         mem_req_ready,
	input logic         wb_valid,
	input lq_wb_t       wb,
	input logic         wb_ready
);

	int errors  = 0;
	int pending = 0;	// Loads in flight
	int credits = LQ_DEPTH;

	// Scoreboard keyed by rob_idx
	logic                 exp_valid [2**ROB_IDX_W];
	logic [PRF_TAG_W-1:0] exp_dest  [2**ROB_IDX_W];
	logic [XLEN-1:0]      exp_pc    [2**ROB_IDX_W];
	logic [XLEN-1:0]      exp_data  [2**ROB_IDX_W];

	logic        wb_held  = 1'b0;
	lq_wb_t      wb_last;
	logic        req_held = 1'b0;
	lq_mem_req_t req_last;

	// Memory data is the address XOR a key rotated by the low address bits
	function automatic logic [XLEN-1:0] mem_value(input logic [XLEN-1:0] addr);
		logic [XLEN-1:0] key;
		int              sh;
		key = 64'h9e37_79b9_7f4a_7c15;
		sh  = int'(addr[5:0]);
		return addr ^ ((key >> sh) | (key << (XLEN - sh)));
	endfunction

	// Base value broadcast for a physical register tag
	function automatic logic [XLEN-1:0] cdb_value(input logic [PRF_TAG_W-1:0] tag);
		return 64'h0000_7000_0000_0000 | (XLEN'(tag) << 16);
	endfunction

	task automatic record_load(input lq_dispatch_t d);
		logic [XLEN-1:0] base;
		base = d.opb_valid ? d.opb : cdb_value(d.opb[PRF_TAG_W-1:0]);
		if (exp_valid[d.rob_idx]) begin
			$display("rob_idx %h dispatched again while still in flight", d.rob_idx);
			errors++;
		end else begin
			pending++;
		end
		exp_valid[d.rob_idx] = 1'b1;
		exp_dest[d.rob_idx]  = d.dest_tag;
		exp_pc[d.rob_idx]    = d.pc;
		exp_data[d.rob_idx]  = mem_value(d.opa + base);
	endtask

	task automatic check_wb(input lq_wb_t w);
		if (!exp_valid[w.rob_idx]) begin
			$display("writeback for rob_idx %h, which has no load in flight", w.rob_idx);
			errors++;
		end else begin
			if (w.dest_tag !== exp_dest[w.rob_idx]) begin
				$display("error wb.dest_tag rob_idx %h: got %h, expected %h",
					w.rob_idx, w.dest_tag, exp_dest[w.rob_idx]);
				errors++;
			end
			if (w.pc !== exp_pc[w.rob_idx]) begin
				$display("error wb.pc rob_idx %h: got %h, expected %h",
					w.rob_idx, w.pc, exp_pc[w.rob_idx]);
				errors++;
			end
			if (w.data !== exp_data[w.rob_idx]) begin
				$display("error wb.data rob_idx %h: got %h, expected %h",
					w.rob_idx, w.data, exp_data[w.rob_idx]);
				errors++;
			end
			exp_valid[w.rob_idx] = 1'b0;
			pending--;
		end
	endtask

	always @(posedge clock) begin
		if (reset || clean) begin
			for (int i = 0; i < 2**ROB_IDX_W; i++) begin
				exp_valid[i] = 1'b0;	// Flushed loads must never write back
			end
			pending  = 0;
			credits  = LQ_DEPTH;
			wb_held  = 1'b0;
			req_held = 1'b0;
		end else begin
			credits = credits + int'(disp_credit) - int'(disp0.valid) - int'(disp1.valid);
			if (credits < 0 || credits > LQ_DEPTH) begin
				$display("dispatch credit count %0d is outside 0 to %0d", credits, LQ_DEPTH);
				errors++;
			end
			if (disp0.valid) record_load(disp0);
			if (disp1.valid) record_load(disp1);
			if (wb_held && !(wb_valid && wb === wb_last)) begin
				$display("writeback changed or dropped while wb_ready was low");
				errors++;
			end
			if (req_held && !(mem_req_valid && mem_req === req_last)) begin
				$display("memory request changed or dropped while mem_req_ready was low");
				errors++;
			end
			if (wb_valid && wb_ready) check_wb(wb);
			wb_held  = wb_valid && !wb_ready;
			wb_last  = wb;
			req_held = mem_req_valid && !mem_req_ready;
			req_last = mem_req;
		end
	end

endmodule

// File: lq_dispatch.sv
`timescale 1ns/1ps

module lq_dispatch
	import lq_pkg::*;
(
	input  logic                clock,
	input  logic                reset,
	input  logic                clean,
	input  lq_dispatch_t        disp0,
	input  lq_dispatch_t        disp1,
	input  logic [LQ_DEPTH-1:0] entry_inuse,
	input  logic [LQ_DEPTH-1:0] entry_free,
	output logic [LQ_DEPTH-1:0] alloc,
	output logic [LQ_DEPTH-1:0] alloc_slot,	// 0 takes disp0, 1 takes disp1
	output logic                disp_credit
);

	logic                first_found;
	logic                second_found;
	logic [LQ_IDX_W-1:0] first_idx;
	logic [LQ_IDX_W-1:0] second_idx;

	// First and second free entry, lowest index first
	always_comb begin
		first_found  = 1'b0;
		second_found = 1'b0;
		first_idx    = '0;
		second_idx   = '0;
		for (int i = 0; i < LQ_DEPTH; i++) begin
			if (!entry_inuse[i]) begin
				if (!first_found) begin
					first_found = 1'b1;
					first_idx   = LQ_IDX_W'(i);
				end else if (!second_found) begin
					second_found = 1'b1;
					second_idx   = LQ_IDX_W'(i);
				end
			end
		end
	end

	always_comb begin
		alloc      = '0;
		alloc_slot = '0;
		if (!clean) begin
			if (disp0.valid && first_found) begin
				alloc[first_idx]      = 1'b1;
				alloc_slot[first_idx] = 1'b0;
			end
			if (disp1.valid) begin
				if (disp0.valid) begin
					alloc[second_idx]      = second_found;	// Slot 1 behind slot 0
					alloc_slot[second_idx] = 1'b1;
				end else begin
					alloc[first_idx]      = first_found;	// Slot 1 alone
					alloc_slot[first_idx] = 1'b1;
				end
			end
		end
	end

	// At most one entry frees per cycle, so one credit per pulse
	always_ff @(posedge clock) begin
		if (reset || clean) begin
			disp_credit <= 1'b0;
		end else begin
			disp_credit <= |entry_free;
		end
	end

endmodule

// File: lq_drain.sv
`timescale 1ns/1ps

module lq_drain
	import lq_pkg::*;
(
	input  logic                clock,
	input  logic                reset,
	input  logic                clean,
	input  lq_entry_status_t    status [LQ_DEPTH],
	input  lq_wb_t              wb_rec [LQ_DEPTH],
	input  logic                mem_req_ready,
	input  lq_mem_resp_t        mem_resp,
	input  logic                wb_ready,
	output logic                mem_req_valid,
	output lq_mem_req_t         mem_req,
	output logic [LQ_DEPTH-1:0] issued,
	output logic [LQ_DEPTH-1:0] resp_strobe,
	output logic [XLEN-1:0]     resp_data,
	output logic                wb_valid,
	output lq_wb_t              wb,
	output logic [LQ_DEPTH-1:0] free
);

	logic [LQ_DEPTH-1:0] req_cand;
	logic [LQ_DEPTH-1:0] wb_cand;
	logic [LQ_IDX_W-1:0] req_idx;
	logic [LQ_IDX_W-1:0] wb_idx;
	logic                req_lock;	// Holds the entry of a stalled request
	logic [LQ_IDX_W-1:0] req_lock_idx;
	logic                wb_lock;
	logic [LQ_IDX_W-1:0] wb_lock_idx;
	logic                req_fire;
	logic                wb_fire;

	function automatic logic [LQ_IDX_W-1:0] lowest_idx(input logic [LQ_DEPTH-1:0] vec);
		logic [LQ_IDX_W-1:0] idx;
		idx = '0;
		for (int i = LQ_DEPTH - 1; i >= 0; i--) begin
			if (vec[i]) idx = LQ_IDX_W'(i);
		end
		return idx;
	endfunction

	always_comb begin
		for (int i = 0; i < LQ_DEPTH; i++) begin
			req_cand[i] = status[i].inuse && status[i].addr_ready && !status[i].issued;
			wb_cand[i]  = status[i].inuse && status[i].done;
		end
	end

	// A stalled pick stays put even if a lower entry turns ready
	assign req_idx       = req_lock ? req_lock_idx : lowest_idx(req_cand);
	assign wb_idx        = wb_lock ? wb_lock_idx : lowest_idx(wb_cand);
	assign mem_req_valid = !clean && (req_lock || |req_cand);
	assign wb_valid      = !clean && (wb_lock || |wb_cand);
	assign req_fire      = mem_req_valid && mem_req_ready;
	assign wb_fire       = wb_valid && wb_ready;

	always_comb begin
		mem_req.addr = status[req_idx].addr;
		mem_req.tag  = req_idx;
		wb           = wb_rec[wb_idx];
		issued       = '0;
		free         = '0;
		issued[req_idx] = req_fire;
		free[wb_idx]    = wb_fire;
	end

	// Stale or stray responses are dropped here
	always_comb begin
		resp_strobe = '0;
		if (mem_resp.valid && !clean && status[mem_resp.tag].inuse &&
				status[mem_resp.tag].issued) begin
			resp_strobe[mem_resp.tag] = 1'b1;
		end
	end

	assign resp_data = mem_resp.data;

	always_ff @(posedge clock) begin
		if (reset || clean) begin
			req_lock     <= 1'b0;
			req_lock_idx <= '0;
			wb_lock      <= 1'b0;
			wb_lock_idx  <= '0;
		end else begin
			req_lock     <= mem_req_valid && !mem_req_ready;
			req_lock_idx <= req_idx;
			wb_lock      <= wb_valid && !wb_ready;
			wb_lock_idx  <= wb_idx;
		end
	end

endmodule

// File: lq_entry.sv
`timescale 1ns/1ps

module lq_entry
	import lq_pkg::*;
(
	input  logic             clock,
	input  logic             reset,
	input  logic             clean,
	input  logic             alloc,
	input  logic             alloc_slot,
	input  lq_dispatch_t     disp0,
	input  lq_dispatch_t     disp1,
	input  cdb_t             cdb1,
	input  cdb_t             cdb2,
	input  logic             issued,
	input  logic             resp_strobe,
	input  logic [XLEN-1:0]  resp_data,
	input  logic             free,
	output lq_entry_status_t status,
	output lq_wb_t           wb_rec
);

	// Control state
	logic inuse;
	logic addr_ready;
	logic is_issued;
	logic is_done;

	// Payload
	logic [XLEN-1:0]      pc;
	logic [XLEN-1:0]      opa;
	logic [XLEN-1:0]      opb;
	logic [XLEN-1:0]      addr;
	logic [ROB_IDX_W-1:0] rob_idx;
	logic [PRF_TAG_W-1:0] dest_tag;
	logic [XLEN-1:0]      data;

	lq_dispatch_t    src;
	logic            snoop;
	logic [XLEN-1:0] cur_opa;
	logic [XLEN-1:0] cur_opb;
	logic            cur_ready;
	logic            hit1;
	logic            hit2;
	logic [XLEN-1:0] opb_next;
	logic            ready_next;

	// Operands come from the new slot on alloc, else from the entry itself
	always_comb begin
		src       = alloc_slot ? disp1 : disp0;
		snoop     = alloc || inuse;
		cur_opa   = alloc ? src.opa : opa;
		cur_opb   = alloc ? src.opb : opb;
		cur_ready = alloc ? src.opb_valid : addr_ready;
		hit1 = snoop && !cur_ready && cdb1.valid && (cdb1.tag == cur_opb[PRF_TAG_W-1:0]);
		hit2 = snoop && !cur_ready && cdb2.valid && (cdb2.tag == cur_opb[PRF_TAG_W-1:0]);
		if (hit1) begin
			opb_next = cdb1.data;	// cdb1 wins a double match
		end else if (hit2) begin
			opb_next = cdb2.data;
		end else begin
			opb_next = cur_opb;
		end
		ready_next = cur_ready || hit1 || hit2;
	end

	always_ff @(posedge clock) begin
		if (reset || clean || free) begin
			inuse      <= 1'b0;
			addr_ready <= 1'b0;
			is_issued  <= 1'b0;
			is_done    <= 1'b0;
		end else begin
			if (alloc) begin
				inuse <= 1'b1;
			end
			if (snoop) begin
				addr_ready <= ready_next;
			end
			if (alloc) begin
				is_issued <= 1'b0;
				is_done   <= 1'b0;
			end else begin
				if (issued) is_issued <= 1'b1;
				if (resp_strobe) is_done <= 1'b1;
			end
		end
	end

	always_ff @(posedge clock) begin
		if (alloc) begin
			pc       <= src.pc;
			rob_idx  <= src.rob_idx;
			dest_tag <= src.dest_tag;
		end
		if (snoop && !addr_ready) begin
			opa  <= cur_opa;
			opb  <= opb_next;
			addr <= cur_opa + opb_next;	// Registered with addr_ready
		end
		if (resp_strobe) begin
			data <= resp_data;
		end
	end

	always_comb begin
		status.inuse      = inuse;
		status.addr_ready = addr_ready;
		status.issued     = is_issued;
		status.done       = is_done;
		status.addr       = addr;
		wb_rec.rob_idx    = rob_idx;
		wb_rec.dest_tag   = dest_tag;
		wb_rec.pc         = pc;
		wb_rec.data       = data;
	end

endmodule

// File: lq_pkg.sv
package lq_pkg;

	localparam int LQ_DEPTH  = 8;
	localparam int LQ_IDX_W  = 3;
	localparam int ROB_IDX_W = 6;	// 32-entry ROB plus wrap bit
	localparam int PRF_TAG_W = 6;
	localparam int XLEN      = 64;

	// One dispatch slot from rename
	typedef struct packed {
		logic                 valid;
		logic [XLEN-1:0]      pc;
		logic [31:0]          inst;
		logic [XLEN-1:0]      opa;		// Base data
		logic [XLEN-1:0]      opb;		// Data, or tag in low bits
		logic                 opb_valid;
		logic [ROB_IDX_W-1:0] rob_idx;
		logic [PRF_TAG_W-1:0] dest_tag;
	} lq_dispatch_t;

	typedef struct packed {
		logic                 valid;
		logic [PRF_TAG_W-1:0] tag;
		logic [XLEN-1:0]      data;
	} cdb_t;

	typedef struct packed {
		logic [XLEN-1:0]     addr;
		logic [LQ_IDX_W-1:0] tag;		// Entry index
	} lq_mem_req_t;

	typedef struct packed {
		logic                valid;
		logic [LQ_IDX_W-1:0] tag;
		logic [XLEN-1:0]     data;
	} lq_mem_resp_t;

	typedef struct packed {
		logic [ROB_IDX_W-1:0] rob_idx;
		logic [PRF_TAG_W-1:0] dest_tag;
		logic [XLEN-1:0]      pc;
		logic [XLEN-1:0]      data;
	} lq_wb_t;

	// Entry summary seen by the drain stage
	typedef struct packed {
		logic            inuse;
		logic            addr_ready;
		logic            issued;
		logic            done;
		logic [XLEN-1:0] addr;
	} lq_entry_status_t;

endpackage

// File: tb_load_queue.sv
`timescale 1ns/1ps

module tb_load_queue
	import lq_pkg::*;
();

	logic         clock;
	logic         reset;
	logic         clean;
	lq_dispatch_t disp0;
	lq_dispatch_t disp1;
	logic         disp_credit;
	cdb_t         cdb1;
	cdb_t         cdb2;
	logic         mem_req_valid;
	lq_mem_req_t  mem_req;
	logic         mem_req_ready;
	lq_mem_resp_t mem_resp;
	logic         wb_valid;
	lq_wb_t       wb;
	logic         wb_ready;

	int          credits    = LQ_DEPTH;	// Sender side credit count
	int          loads_left = 0;
	int          tag_pct    = 0;
	bit          dual_ok    = 1'b0;
	bit          do_clean   = 1'b0;
	bit          wb_hold    = 1'b0;
	int          stretch    = 0;
	int          cycle      = 0;
	int          seq        = 0;
	int          tb_errors  = 0;

	logic [PRF_TAG_W-1:0] tag_q [$];	// Tags still owed a broadcast
	logic [LQ_IDX_W-1:0]  resp_tag_q [$];
	logic [XLEN-1:0]      resp_data_q [$];
	int                   resp_due_q [$];

	load_queue DUT (.*);

	lq_checker u_checker (.*);

	initial begin
		clock = 1'b0;
		forever #2 clock = ~clock;
	end

	function automatic lq_dispatch_t make_load(input int n, input bit use_tag);
		lq_dispatch_t d;
		d           = '0;
		d.valid     = 1'b1;
		d.pc        = 64'h0000_0000_8000_0000 + XLEN'(n) * 4;
		d.inst      = $urandom;
		d.opa       = {$urandom, $urandom};
		d.opb       = use_tag ? XLEN'($urandom % 64) : XLEN'($urandom % 4096);
		d.opb_valid = !use_tag;
		d.rob_idx   = ROB_IDX_W'(n);
		d.dest_tag  = PRF_TAG_W'($urandom);
		return d;
	endfunction

	// One clock of stimulus, memory model and credit bookkeeping
	task automatic step();
		lq_dispatch_t slot [2];
		cdb_t         bc [2];
		lq_mem_resp_t resp;
		int           hit;
		@(posedge clock);
		cycle++;
		if (clean) begin
			credits = LQ_DEPTH;	// Queue is empty after a flush
		end else if (disp_credit) begin
			credits++;
		end
		if (mem_req_valid && mem_req_ready) begin
			resp_tag_q.push_back(mem_req.tag);
			resp_data_q.push_back(u_checker.mem_value(mem_req.addr));
			resp_due_q.push_back(cycle + int'($urandom % 6));	// 1 to 6 cycles later
		end
		resp = '0;
		hit  = -1;
		for (int i = 0; i < resp_due_q.size(); i++) begin
			if (hit < 0 && resp_due_q[i] <= cycle) hit = i;
		end
		if (do_clean) begin
			resp_tag_q.delete();
			resp_data_q.delete();
			resp_due_q.delete();
			tag_q.delete();
		end else if (hit >= 0) begin
			resp.valid = 1'b1;
			resp.tag   = resp_tag_q[hit];
			resp.data  = resp_data_q[hit];
			resp_tag_q.delete(hit);
			resp_data_q.delete(hit);
			resp_due_q.delete(hit);
		end
		for (int s = 0; s < 2; s++) begin
			slot[s] = '0;
			if (!do_clean && loads_left > 0 && credits > 0 && (s == 0 || dual_ok) &&
					($urandom % 4) != 0) begin
				slot[s] = make_load(seq, ($urandom % 100) < tag_pct);
				if (!slot[s].opb_valid) tag_q.push_back(slot[s].opb[PRF_TAG_W-1:0]);
				seq++;
				loads_left--;
				credits--;
			end
		end
		// A tag pushed above may go out in its own dispatch cycle
		for (int s = 0; s < 2; s++) begin
			bc[s] = '0;
			if (tag_q.size() > 0 && ($urandom % 2) != 0) begin
				bc[s].valid = 1'b1;
				bc[s].tag   = tag_q.pop_front();
				bc[s].data  = u_checker.cdb_value(bc[s].tag);
			end
		end
		clean         <= do_clean;
		do_clean      = 1'b0;
		disp0         <= slot[0];
		disp1         <= slot[1];
		cdb1          <= bc[0];
		cdb2          <= bc[1];
		mem_resp      <= resp;
		mem_req_ready <= ($urandom % 4) != 0;
		if (stretch == 0) begin
			stretch = 1 + int'($urandom % 8);
			wb_hold = ($urandom % 3) == 0;	// Stretches of writeback back-pressure
		end
		stretch--;
		wb_ready <= !wb_hold;
	endtask

	task automatic load_phase(input int count, input int pct, input bit dual);
		int waited;
		loads_left = count;
		tag_pct    = pct;
		dual_ok    = dual;
		waited     = 0;
		while (loads_left > 0 && waited < 100 * count) begin
			step();
			waited++;
		end
		if (loads_left > 0) begin
			$display("timeout: %0d loads never got a dispatch credit", loads_left);
			tb_errors++;
			loads_left = 0;
		end
	endtask

	task automatic wait_idle();
		int waited;
		waited = 0;
		while (credits != LQ_DEPTH && waited < 2000) begin
			step();
			waited++;
		end
		if (credits != LQ_DEPTH) begin
			$display("timeout: only %0d of %0d dispatch credits came back", credits, LQ_DEPTH);
			tb_errors++;
		end
		if (u_checker.pending != 0) begin
			$display("%0d loads never wrote back", u_checker.pending);
			tb_errors++;
		end
	endtask

	initial begin
		void'($urandom(60));
		reset         = 1'b1;
		clean         = 1'b0;
		disp0         = '0;
		disp1         = '0;
		cdb1          = '0;
		cdb2          = '0;
		mem_req_ready = 1'b0;
		mem_resp      = '0;
		wb_ready      = 1'b0;
		repeat (2) @(posedge clock);
		reset <= 1'b0;
		load_phase(24, 0, 1'b0);	// Immediate base with one slot per cycle
		load_phase(24, 0, 1'b1);	// Immediate base on both slots
		load_phase(40, 50, 1'b1);	// Half of them wait on the CDB
		load_phase(16, 50, 1'b1);
		repeat (3) step();
		do_clean = 1'b1;	// Flush with loads in flight
		step();
		load_phase(30, 50, 1'b1);
		wait_idle();
		$display("errors: checker %0d, testbench %0d", u_checker.errors, tb_errors);
		if (u_checker.errors == 0 && tb_errors == 0) begin
			$display("*** PASSED ***");
		end else begin
			$display("*** FAILED ***");
		end
		$finish;
	end

endmodule
